// ==== build.f ====
+incdir+include
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/rbank.sv
logic/alu_stage.sv
logic/mem_stage.sv
logic/cpu.sv
testbench/tb_cpu.sv

// ==== include/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath word width
`define CPU_DATA_WIDTH 32

// Byte address width for PC and data accesses
`define CPU_ADDR_WIDTH 32

// Register number width for 32 architectural registers
`define CPU_REG_BITS 5

// Instruction memory depth in words
`define CPU_IMEM_WORDS 64

// Data memory depth in words
`define CPU_DMEM_WORDS 64

`endif

// ==== logic/alu_stage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu_stage (
  input  logic                         valid_i,
  input  cpu_pkg::dec_alu_t            dec_i,
  output cpu_pkg::alu_mem_t            res_o,
  output logic                         redirect_o,
  output logic [`CPU_ADDR_WIDTH-1:0]   target_o
);

  logic [`CPU_DATA_WIDTH-1:0] sum_imm;
  logic [`CPU_ADDR_WIDTH-1:0] imm_bytes;
  logic                       taken;

  assign sum_imm   = dec_i.reg_a_data + dec_i.immediate;
  // Branch and jump offsets count words
  assign imm_bytes = {dec_i.immediate[`CPU_ADDR_WIDTH-3:0], 2'b00};

  always_comb begin
    res_o.pc         = dec_i.pc;
    res_o.opcode     = dec_i.opcode;
    res_o.store_data = dec_i.reg_b_data;
    res_o.wr_reg     = dec_i.wr_reg;
    res_o.wr_en      = dec_i.wr_en;
    res_o.is_load    = 1'b0;
    res_o.is_store   = 1'b0;
    res_o.alu_result = '0;
    taken            = 1'b0;
    target_o         = imm_bytes;
    case (dec_i.opcode)
      cpu_pkg::ADD:  res_o.alu_result = dec_i.reg_a_data + dec_i.reg_b_data;
      cpu_pkg::SUB:  res_o.alu_result = dec_i.reg_a_data - dec_i.reg_b_data;
      cpu_pkg::AND:  res_o.alu_result = dec_i.reg_a_data & dec_i.reg_b_data;
      cpu_pkg::OR:   res_o.alu_result = dec_i.reg_a_data | dec_i.reg_b_data;
      cpu_pkg::ADDI: res_o.alu_result = sum_imm;
      cpu_pkg::LW: begin
        res_o.alu_result = sum_imm;
        res_o.is_load    = 1'b1;
      end
      cpu_pkg::SW: begin
        res_o.alu_result = sum_imm;
        res_o.is_store   = 1'b1;
      end
      cpu_pkg::BEQ: begin
        taken    = (dec_i.reg_a_data == dec_i.reg_b_data);
        target_o = dec_i.pc + 4 + imm_bytes;
      end
      cpu_pkg::JMP: taken = 1'b1;
      default: res_o.alu_result = '0;
    endcase
  end

  // Bubbles must never steer the fetch
  assign redirect_o = valid_i && taken;

endmodule

// ==== logic/cpu.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 imem_we_i,
  input  logic [$clog2(`CPU_IMEM_WORDS)-1:0]   imem_addr_i,
  input  logic [`CPU_DATA_WIDTH-1:0]           imem_data_i,
  output logic                                 retire_valid_o,
  output cpu_pkg::retire_t                     retire_o
);

  // Fetch
  logic [`CPU_ADDR_WIDTH-1:0] fetch_pc;
  cpu_pkg::instruction_u      fetch_instr;

  // F/D register
  logic                       fd_valid;
  logic [`CPU_ADDR_WIDTH-1:0] fd_pc;
  cpu_pkg::instruction_u      fd_instr;

  // Decode and register bank
  cpu_pkg::dec_alu_t          dec_out;
  logic [`CPU_REG_BITS-1:0]   rd_addr_a;
  logic [`CPU_REG_BITS-1:0]   rd_addr_b;
  logic [`CPU_DATA_WIDTH-1:0] rd_data_a;
  logic [`CPU_DATA_WIDTH-1:0] rd_data_b;

  // D/A register and ALU
  logic                       da_valid;
  cpu_pkg::dec_alu_t          da_q;
  cpu_pkg::alu_mem_t          alu_out;
  logic                       redirect;
  logic [`CPU_ADDR_WIDTH-1:0] target;

  // A/M register and memory
  logic                       am_valid;
  cpu_pkg::alu_mem_t          am_q;
  logic [`CPU_DATA_WIDTH-1:0] load_data;
  cpu_pkg::mem_wb_t           mw_d;

  // M/W register and writeback
  logic                       mw_valid;
  cpu_pkg::mem_wb_t           mw_q;
  logic [`CPU_DATA_WIDTH-1:0] wb_data;

  fetch_stage u_fetch (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .imem_we_i   (imem_we_i),
    .imem_addr_i (imem_addr_i),
    .imem_data_i (imem_data_i),
    .redirect_i  (redirect),
    .target_i    (target),
    .pc_o        (fetch_pc),
    .instr_o     (fetch_instr)
  );

  decode_stage u_decode (
    .instr_i     (fd_instr),
    .pc_i        (fd_pc),
    .rd_addr_a_o (rd_addr_a),
    .rd_addr_b_o (rd_addr_b),
    .rd_data_a_i (rd_data_a),
    .rd_data_b_i (rd_data_b),
    .dec_o       (dec_out)
  );

  rbank u_rbank (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .we_i        (mw_valid && mw_q.wr_en),
    .wr_reg_i    (mw_q.wr_reg),
    .wr_data_i   (wb_data),
    .rd_reg_a_i  (rd_addr_a),
    .rd_reg_b_i  (rd_addr_b),
    .rd_data_a_o (rd_data_a),
    .rd_data_b_o (rd_data_b)
  );

  alu_stage u_alu (
    .valid_i    (da_valid),
    .dec_i      (da_q),
    .res_o      (alu_out),
    .redirect_o (redirect),
    .target_o   (target)
  );

  mem_stage u_mem (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (am_valid),
    .req_i       (am_q),
    .load_data_o (load_data)
  );

  always_comb begin
    mw_d.pc         = am_q.pc;
    mw_d.alu_result = am_q.alu_result;
    mw_d.load_data  = load_data;
    mw_d.wr_reg     = am_q.wr_reg;
    mw_d.wr_en      = am_q.wr_en;
    mw_d.is_load    = am_q.is_load;
    mw_d.is_store   = am_q.is_store;
    mw_d.store_data = am_q.store_data;
  end

  // A redirect squashes the two younger instructions in F and D
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      fd_valid <= 1'b0;
      da_valid <= 1'b0;
      am_valid <= 1'b0;
      mw_valid <= 1'b0;
    end else begin
      fd_valid <= !redirect;
      da_valid <= fd_valid && !redirect;
      am_valid <= da_valid;
      mw_valid <= am_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    fd_pc    <= fetch_pc;
    fd_instr <= fetch_instr;
    da_q     <= dec_out;
    am_q     <= alu_out;
    mw_q     <= mw_d;
  end

  assign wb_data = mw_q.is_load ? mw_q.load_data : mw_q.alu_result;

  assign retire_valid_o = mw_valid;

  always_comb begin
    retire_o.pc         = mw_q.pc;
    retire_o.wr_en      = mw_q.wr_en;
    retire_o.wr_reg     = mw_q.wr_reg;
    retire_o.wr_data    = wb_data;
    retire_o.is_store   = mw_q.is_store;
    retire_o.store_addr = mw_q.alu_result;
    retire_o.store_data = mw_q.store_data;
  end

  a_retire_known : assert property (
    @(posedge clk_i) disable iff (!rst_i) !$isunknown(retire_valid_o)
  ) else $error("Retire valid is unknown");

endmodule

// ==== logic/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

  typedef enum logic [5:0] {
    NOP  = 6'd0,
    ADD  = 6'd1,
    SUB  = 6'd2,
    AND  = 6'd3,
    OR   = 6'd4,
    ADDI = 6'd5,
    LW   = 6'd6,
    SW   = 6'd7,
    BEQ  = 6'd8,
    JMP  = 6'd9
  } opcode_e;

  // Register format where rd = ra op rb
  typedef struct packed {
    opcode_e                   opcode;
    logic [`CPU_REG_BITS-1:0]  rd;
    logic [`CPU_REG_BITS-1:0]  ra;
    logic [`CPU_REG_BITS-1:0]  rb;
    logic [10:0]               unused;
  } instr_r_t;

  // Immediate format where SW and BEQ carry their rb in the rd slot
  typedef struct packed {
    opcode_e                   opcode;
    logic [`CPU_REG_BITS-1:0]  rd;
    logic [`CPU_REG_BITS-1:0]  ra;
    logic signed [15:0]        imm;
  } instr_i_t;

  typedef union packed {
    instr_r_t rtype;
    instr_i_t itype;
  } instruction_u;

  typedef struct packed {
    logic [`CPU_ADDR_WIDTH-1:0] pc;
    opcode_e                    opcode;
    logic [`CPU_DATA_WIDTH-1:0] reg_a_data;
    logic [`CPU_DATA_WIDTH-1:0] reg_b_data;
    logic [`CPU_DATA_WIDTH-1:0] immediate;
    logic [`CPU_REG_BITS-1:0]   wr_reg;
    logic                       wr_en;
  } dec_alu_t;

  typedef struct packed {
    logic [`CPU_ADDR_WIDTH-1:0] pc;
    opcode_e                    opcode;
    logic [`CPU_DATA_WIDTH-1:0] alu_result;
    logic [`CPU_DATA_WIDTH-1:0] store_data;
    logic [`CPU_REG_BITS-1:0]   wr_reg;
    logic                       wr_en;
    logic                       is_load;
    logic                       is_store;
  } alu_mem_t;

  typedef struct packed {
    logic [`CPU_ADDR_WIDTH-1:0] pc;
    logic [`CPU_DATA_WIDTH-1:0] alu_result;
    logic [`CPU_DATA_WIDTH-1:0] load_data;
    logic [`CPU_REG_BITS-1:0]   wr_reg;
    logic                       wr_en;
    logic                       is_load;
    logic                       is_store;
    logic [`CPU_DATA_WIDTH-1:0] store_data;
  } mem_wb_t;

  typedef struct packed {
    logic [`CPU_ADDR_WIDTH-1:0] pc;
    logic                       wr_en;
    logic [`CPU_REG_BITS-1:0]   wr_reg;
    logic [`CPU_DATA_WIDTH-1:0] wr_data;
    logic                       is_store;
    logic [`CPU_ADDR_WIDTH-1:0] store_addr;
    logic [`CPU_DATA_WIDTH-1:0] store_data;
  } retire_t;

endpackage

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decode_stage (
  input  cpu_pkg::instruction_u          instr_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]     pc_i,
  output logic [`CPU_REG_BITS-1:0]       rd_addr_a_o,
  output logic [`CPU_REG_BITS-1:0]       rd_addr_b_o,
  input  logic [`CPU_DATA_WIDTH-1:0]     rd_data_a_i,
  input  logic [`CPU_DATA_WIDTH-1:0]     rd_data_b_i,
  output cpu_pkg::dec_alu_t              dec_o
);

  cpu_pkg::opcode_e op;
  logic             r_format;
  logic             writes_reg;

  // Opcode, rd and ra sit in the same bits in both formats
  assign op = instr_i.rtype.opcode;

  always_comb begin
    r_format   = 1'b0;
    writes_reg = 1'b0;
    case (op)
      cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR: begin
        r_format   = 1'b1;
        writes_reg = 1'b1;
      end
      cpu_pkg::ADDI, cpu_pkg::LW: writes_reg = 1'b1;
      default: writes_reg = 1'b0;
    endcase
  end

  // SW and BEQ find their second source in the rd slot of the immediate format
  assign rd_addr_a_o = instr_i.itype.ra;
  assign rd_addr_b_o = r_format ? instr_i.rtype.rb : instr_i.itype.rd;

  always_comb begin
    dec_o.pc         = pc_i;
    dec_o.opcode     = op;
    dec_o.reg_a_data = rd_data_a_i;
    dec_o.reg_b_data = rd_data_b_i;
    dec_o.immediate  = r_format ? '0 :
                       {{(`CPU_DATA_WIDTH-16){instr_i.itype.imm[15]}}, instr_i.itype.imm};
    dec_o.wr_en      = writes_reg;
    dec_o.wr_reg     = '0;
    if (writes_reg) begin
      dec_o.wr_reg = instr_i.itype.rd;
    end
  end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_stage (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 imem_we_i,
  input  logic [$clog2(`CPU_IMEM_WORDS)-1:0]   imem_addr_i,
  input  logic [`CPU_DATA_WIDTH-1:0]           imem_data_i,
  input  logic                                 redirect_i,
  input  logic [`CPU_ADDR_WIDTH-1:0]           target_i,
  output logic [`CPU_ADDR_WIDTH-1:0]           pc_o,
  output cpu_pkg::instruction_u                instr_o
);

  localparam int IMEM_AW = $clog2(`CPU_IMEM_WORDS);

  logic [`CPU_DATA_WIDTH-1:0] imem [`CPU_IMEM_WORDS];
  logic [`CPU_ADDR_WIDTH-1:0] pc_q;

  // A taken branch or jump from the ALU overrides the sequential PC
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q <= '0;
    end else if (redirect_i) begin
      pc_q <= target_i;
    end else begin
      pc_q <= pc_q + 4;
    end
  end

  // Program image goes in only while the core sits in reset
  always_ff @(posedge clk_i) begin
    if (imem_we_i && !rst_i) begin
      imem[imem_addr_i] <= imem_data_i;
    end
  end

  assign pc_o    = pc_q;
  assign instr_o = imem[pc_q[IMEM_AW+1:2]];

  a_load_in_reset : assert property (@(posedge clk_i) rst_i |-> !imem_we_i)
    else $error("Instruction memory written while the core is running");

endmodule

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mem_stage (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         valid_i,
  input  cpu_pkg::alu_mem_t            req_i,
  output logic [`CPU_DATA_WIDTH-1:0]   load_data_o
);

  localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

  logic [`CPU_DATA_WIDTH-1:0] dmem [`CPU_DMEM_WORDS];
  logic [DMEM_AW-1:0]         word_idx;

  // Byte address to word index
  assign word_idx = req_i.alu_result[DMEM_AW+1:2];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int k = 0; k < `CPU_DMEM_WORDS; k++) begin
        dmem[k] <= '0;
      end
    end else if (valid_i && req_i.is_store) begin
      dmem[word_idx] <= req_i.store_data;
    end
  end

  // Load data is ready in the same cycle and gets captured in M/W
  assign load_data_o = dmem[word_idx];

  a_dmem_range : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    valid_i && (req_i.is_load || req_i.is_store)
      |-> (req_i.alu_result >> 2) < `CPU_DMEM_WORDS
  ) else $error("Data access outside memory at address %h", req_i.alu_result);

endmodule

// ==== logic/rbank.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module rbank (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         we_i,
  input  logic [`CPU_REG_BITS-1:0]     wr_reg_i,
  input  logic [`CPU_DATA_WIDTH-1:0]   wr_data_i,
  input  logic [`CPU_REG_BITS-1:0]     rd_reg_a_i,
  input  logic [`CPU_REG_BITS-1:0]     rd_reg_b_i,
  output logic [`CPU_DATA_WIDTH-1:0]   rd_data_a_o,
  output logic [`CPU_DATA_WIDTH-1:0]   rd_data_b_o
);

  logic [`CPU_DATA_WIDTH-1:0] regs [2**`CPU_REG_BITS];

  // A write in the same cycle is visible to decode right away
  function automatic logic [`CPU_DATA_WIDTH-1:0] read_port(
    input logic [`CPU_REG_BITS-1:0] sel
  );
    logic [`CPU_DATA_WIDTH-1:0] val;
    if (sel == '0) begin
      val = '0;
    end else if (we_i && (wr_reg_i == sel)) begin
      val = wr_data_i;
    end else begin
      val = regs[sel];
    end
    return val;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int k = 0; k < 2**`CPU_REG_BITS; k++) begin
        regs[k] <= '0;
      end
    end else if (we_i && (wr_reg_i != '0)) begin
      regs[wr_reg_i] <= wr_data_i;
    end
  end

  always_comb begin
    rd_data_a_o = read_port(rd_reg_a_i);
    rd_data_b_o = read_port(rd_reg_b_i);
  end

  a_r0_zero : assert property (@(posedge clk_i) disable iff (!rst_i) regs[0] == '0)
    else $error("Register zero holds a nonzero value");

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds with Verilator, runs the testbench and looks for the pass line
verilator --binary --timescale 1ns/1ps -f build.f --top-module tb_cpu &&
  ./obj_dir/Vtb_cpu | tee /dev/stderr | grep -qF ">>> PASS" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu;

  localparam int IMEM_AW = $clog2(`CPU_IMEM_WORDS);

  logic                       clk_i;
  logic                       rst_i;
  logic                       imem_we_i;
  logic [IMEM_AW-1:0]         imem_addr_i;
  logic [`CPU_DATA_WIDTH-1:0] imem_data_i;
  logic                       retire_valid_o;
  cpu_pkg::retire_t           retire_o;

  logic [31:0]      prog [`CPU_IMEM_WORDS];
  int               prog_len;
  cpu_pkg::retire_t exp_q [$];
  logic [31:0]      rng_state = 32'h7b139ae4;
  int               errors = 0;
  int               checks = 0;
  int               cycle_limit = 0;
  int               run_cycles = 0;

  cpu u_dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .imem_we_i      (imem_we_i),
    .imem_addr_i    (imem_addr_i),
    .imem_data_i    (imem_data_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Budget grows with each program and only counts cycles out of reset
  always @(posedge clk_i) begin
    if (rst_i) begin
      run_cycles = run_cycles + 1;
    end
    if (run_cycles > cycle_limit) begin
      $display("Timeout: the core did not retire the expected instructions in time");
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_imm();
    rng_state = xorshift32(rng_state);
    return int'($signed(rng_state[15:0]));
  endfunction

  function automatic logic [31:0] enc_r(input cpu_pkg::opcode_e op, input int rd, input int ra,
                                        input int rb);
    return {op, 5'(rd), 5'(ra), 5'(rb), 11'b0};
  endfunction

  // SW and BEQ put their second source register in the rd slot
  function automatic logic [31:0] enc_i(input cpu_pkg::opcode_e op, input int rd, input int ra,
                                        input int imm);
    return {op, 5'(rd), 5'(ra), 16'(imm)};
  endfunction

  task automatic add_instr(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic clear_program();
    for (int i = 0; i < `CPU_IMEM_WORDS; i++) begin
      prog[i] = '0;
    end
    prog_len = 0;
  endtask

  // Reference ISA model that emits one record per executed instruction
  task automatic predict_retires();
    logic [31:0]      regs_m [32];
    logic [31:0]      dmem_m [`CPU_DMEM_WORDS];
    logic [31:0]      pc;
    logic [31:0]      next_pc;
    logic [31:0]      w;
    logic [31:0]      imm;
    logic [31:0]      va;
    logic [31:0]      addr;
    logic [31:0]      val;
    logic [4:0]       rd;
    cpu_pkg::retire_t rec;
    int               steps;
    for (int k = 0; k < 32; k++) begin
      regs_m[k] = '0;
    end
    for (int k = 0; k < `CPU_DMEM_WORDS; k++) begin
      dmem_m[k] = '0;
    end
    exp_q.delete();
    pc = '0;
    steps = 0;
    while (pc < 32'(prog_len * 4) && steps < `CPU_IMEM_WORDS) begin
      w = prog[pc[7:2]];
      rd = w[25:21];
      va = regs_m[w[20:16]];
      imm = {{16{w[15]}}, w[15:0]};
      rec = '0;
      rec.pc = pc;
      next_pc = pc + 4;
      val = '0;
      case (cpu_pkg::opcode_e'(w[31:26]))
        cpu_pkg::ADD: val = va + regs_m[w[15:11]];
        cpu_pkg::SUB: val = va - regs_m[w[15:11]];
        cpu_pkg::AND: val = va & regs_m[w[15:11]];
        cpu_pkg::OR: val = va | regs_m[w[15:11]];
        cpu_pkg::ADDI: val = va + imm;
        cpu_pkg::LW: begin
          addr = va + imm;
          val = dmem_m[addr[7:2]];
        end
        cpu_pkg::SW: begin
          addr = va + imm;
          rec.is_store = 1'b1;
          rec.store_addr = addr;
          rec.store_data = regs_m[rd];
          dmem_m[addr[7:2]] = regs_m[rd];
        end
        cpu_pkg::BEQ: begin
          if (va == regs_m[rd]) begin
            next_pc = pc + 4 + (imm << 2);
          end
        end
        cpu_pkg::JMP: next_pc = imm << 2;
        default: val = '0;
      endcase
      case (cpu_pkg::opcode_e'(w[31:26]))
        cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::ADDI, cpu_pkg::LW: begin
          rec.wr_en = 1'b1;
          rec.wr_reg = rd;
          rec.wr_data = val;
          if (rd != 5'd0) begin
            regs_m[rd] = val;
          end
        end
        default: rec.wr_en = 1'b0;
      endcase
      exp_q.push_back(rec);
      pc = next_pc;
      steps++;
    end
  endtask

  // Unused words stay zero, so the core runs into NOPs past the program
  task automatic load_and_reset();
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int i = 0; i < `CPU_IMEM_WORDS; i++) begin
      imem_we_i = 1'b1;
      imem_addr_i = IMEM_AW'(i);
      imem_data_i = prog[i];
      @(negedge clk_i);
    end
    imem_we_i = 1'b0;
    repeat (10) @(negedge clk_i);
  endtask

  task automatic compare_record(input cpu_pkg::retire_t want);
    expect_equal(retire_o.pc, want.pc, "retire pc");
    expect_equal(32'(retire_o.wr_en), 32'(want.wr_en), $sformatf("pc %h wr_en", want.pc));
    if (want.wr_en) begin
      expect_equal(32'(retire_o.wr_reg), 32'(want.wr_reg), $sformatf("pc %h wr_reg", want.pc));
      expect_equal(retire_o.wr_data, want.wr_data, $sformatf("pc %h wr_data", want.pc));
    end
    expect_equal(32'(retire_o.is_store), 32'(want.is_store), $sformatf("pc %h is_store", want.pc));
    if (want.is_store) begin
      expect_equal(retire_o.store_addr, want.store_addr, $sformatf("pc %h store addr", want.pc));
      expect_equal(retire_o.store_data, want.store_data, $sformatf("pc %h store data", want.pc));
    end
  endtask

  task automatic run_program(input bit check_timing);
    int               edges;
    cpu_pkg::retire_t want;
    predict_retires();
    load_and_reset();
    cycle_limit = cycle_limit + prog_len + 20;
    rst_i = 1'b1;
    edges = 0;
    while (exp_q.size() > 0) begin
      @(negedge clk_i);
      edges++;
      if (check_timing) begin
        expect_equal(32'(retire_valid_o), 32'(edges >= 4), "retire valid timing");
      end
      if (retire_valid_o) begin
        want = exp_q.pop_front();
        compare_record(want);
      end
    end
  endtask

  task automatic first_retire_timing();
    clear_program();
    add_instr(enc_i(cpu_pkg::ADDI, 1, 0, rand_imm()));
    add_instr(enc_i(cpu_pkg::ADDI, 2, 0, rand_imm()));
    add_instr(32'h0);
    add_instr(32'h0);
    add_instr(enc_r(cpu_pkg::ADD, 3, 1, 2));
    add_instr(enc_r(cpu_pkg::SUB, 4, 1, 2));
    run_program(1'b1);
  endtask

  // Every consumer sits at least three slots after its producer
  task automatic arithmetic_ops();
    clear_program();
    add_instr(enc_i(cpu_pkg::ADDI, 1, 0, rand_imm()));
    add_instr(enc_i(cpu_pkg::ADDI, 2, 0, rand_imm()));
    add_instr(enc_i(cpu_pkg::ADDI, 3, 0, rand_imm()));
    add_instr(32'h0);
    add_instr(enc_r(cpu_pkg::ADD, 4, 1, 2));
    add_instr(enc_r(cpu_pkg::SUB, 5, 3, 1));
    add_instr(enc_r(cpu_pkg::AND, 6, 1, 3));
    add_instr(enc_r(cpu_pkg::OR, 7, 2, 4));
    add_instr(enc_r(cpu_pkg::SUB, 8, 4, 5));
    add_instr(enc_r(cpu_pkg::ADD, 9, 6, 5));
    add_instr(enc_r(cpu_pkg::AND, 11, 7, 1));
    add_instr(32'h0);
    add_instr(enc_r(cpu_pkg::OR, 10, 8, 9));
    run_program(1'b0);
  endtask

  task automatic zero_register();
    clear_program();
    add_instr(enc_i(cpu_pkg::ADDI, 0, 0, rand_imm() | 1));
    add_instr(enc_i(cpu_pkg::ADDI, 5, 0, rand_imm()));
    add_instr(32'h0);
    add_instr(enc_r(cpu_pkg::ADD, 6, 0, 0));
    add_instr(enc_r(cpu_pkg::OR, 7, 0, 5));
    add_instr(enc_i(cpu_pkg::ADDI, 8, 0, 0));
    run_program(1'b0);
  endtask

  task automatic store_then_load();
    clear_program();
    add_instr(enc_i(cpu_pkg::ADDI, 1, 0, 16));
    add_instr(enc_i(cpu_pkg::ADDI, 2, 0, rand_imm()));
    add_instr(enc_i(cpu_pkg::ADDI, 3, 0, rand_imm()));
    add_instr(32'h0);
    add_instr(enc_i(cpu_pkg::SW, 2, 1, 0));
    add_instr(enc_i(cpu_pkg::SW, 3, 1, 4));
    add_instr(enc_i(cpu_pkg::SW, 2, 1, -8));
    add_instr(enc_i(cpu_pkg::LW, 4, 1, 0));
    add_instr(enc_i(cpu_pkg::LW, 5, 1, 4));
    add_instr(enc_i(cpu_pkg::LW, 6, 1, -8));
    add_instr(enc_i(cpu_pkg::LW, 7, 1, 12));
    add_instr(32'h0);
    add_instr(enc_r(cpu_pkg::ADD, 8, 4, 5));
    run_program(1'b0);
  endtask

  // Registers 10, 11, 13 and 14 are only written by squashed slots
  task automatic branch_and_jump();
    clear_program();
    add_instr(enc_i(cpu_pkg::ADDI, 1, 0, 5));
    add_instr(enc_i(cpu_pkg::ADDI, 2, 0, 5));
    add_instr(enc_i(cpu_pkg::ADDI, 3, 0, 9));
    add_instr(32'h0);
    add_instr(enc_i(cpu_pkg::BEQ, 2, 1, 2));
    add_instr(enc_i(cpu_pkg::ADDI, 10, 0, 1));
    add_instr(enc_i(cpu_pkg::ADDI, 11, 0, 2));
    add_instr(enc_i(cpu_pkg::BEQ, 3, 1, 3));
    add_instr(enc_i(cpu_pkg::ADDI, 12, 0, 3));
    add_instr(enc_i(cpu_pkg::JMP, 0, 0, 13));
    add_instr(enc_i(cpu_pkg::ADDI, 13, 0, 4));
    add_instr(enc_i(cpu_pkg::ADDI, 14, 0, 5));
    add_instr(enc_i(cpu_pkg::ADDI, 15, 0, 6));
    add_instr(enc_r(cpu_pkg::ADD, 16, 12, 1));
    add_instr(32'h0);
    add_instr(32'h0);
    add_instr(enc_r(cpu_pkg::OR, 17, 16, 3));
    add_instr(enc_r(cpu_pkg::ADD, 18, 10, 11));
    run_program(1'b0);
  endtask

  initial begin
    rst_i = 1'b0;
    imem_we_i = 1'b0;
    imem_addr_i = '0;
    imem_data_i = '0;
    first_retire_timing();
    arithmetic_ops();
    zero_register();
    store_then_load();
    branch_and_jump();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
